/* verilog/sbox_pkg.sv */
// lane count, lane index, lane mask, permutation and lane payload types
package sbox_pkg;

   // ******************************
   // lane geometry
   // ******************************

   // the sorting network in the control block is fixed at four items
   localparam int NUM_LANES = 4;
   // bits needed to name one lane
   localparam int LG_LANES  = 2;

   // ******************************
   // lane bookkeeping types
   // ******************************

   // index of a single lane
   typedef logic [LG_LANES-1:0] lane_idx_t;

   // one bit per lane, bit i set when lane i is active
   typedef logic [NUM_LANES-1:0] lane_mask_t;

   // entry j holds the source lane that feeds output lane j
   typedef lane_idx_t [NUM_LANES-1:0] perm_t;

   // ******************************
   // lane payloads
   // ******************************

   // forward direction, from the sparse inputs to the packed outputs
   typedef logic [15:0] fwd_data_t;

   // return direction, from the packed lanes back to the original slots
   typedef logic [7:0] ret_data_t;

endpackage

/* verilog/sbox_wb_pkg.sv */
// Wishbone bus widths, register byte addresses, status bit layout and register reset values
package sbox_wb_pkg;

   // ******************************
   // bus geometry
   // ******************************

   localparam int WB_ADDR_W = 4;
   localparam int WB_DATA_W = 32;

   // ******************************
   // register map
   // ******************************

   // byte addresses, one 32-bit word each
   localparam logic [WB_ADDR_W-1:0] ADDR_MASK   = 4'h0;
   localparam logic [WB_ADDR_W-1:0] ADDR_DRAIN  = 4'h4;
   localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 4'h8;

   // busy flag position in the status word, active mask sits in the low bits
   localparam int STATUS_BUSY_BIT = 8;

   // width of the drain length register and of the timer
   localparam int DRAIN_W = 8;

   // all lanes active out of reset, which gives the identity permutation
   localparam sbox_pkg::lane_mask_t MASK_RESET = '1;

   // default drain time in clock cycles
   localparam logic [DRAIN_W-1:0] DRAIN_RESET = 8'd4;

endpackage

/* verilog/sbox_cfg_if.sv */
// interface carrying pending mask, drain length, start, busy and active mask between regs and FSM
`timescale 1ns/1ps

interface sbox_cfg_if;

   import sbox_pkg::*;
   import sbox_wb_pkg::*;

   // ******************************
   // register block side
   // ******************************

   // last mask written over the bus, not yet in effect
   lane_mask_t pending_mask;
   // drain time in cycles for the next reconfiguration
   logic [DRAIN_W-1:0] drain_len;
   // single cycle request to begin a reconfiguration
   logic start;

   // ******************************
   // state machine side
   // ******************************

   // high while a reconfiguration is in progress
   logic busy;
   // mask currently steering the data path
   lane_mask_t active_mask;

   modport regs_mp (output pending_mask, output drain_len, output start,
                    input busy, input active_mask);

   modport fsm_mp (input pending_mask, input drain_len, input start,
                   output busy, output active_mask);

endinterface

/* verilog/sbox_ctrl_concentrate.sv */
// concentration control: stable four-item sort that derives forward and backward permutations
`timescale 1ns/1ps

module sbox_ctrl_concentrate
  (input  sbox_pkg::lane_mask_t vec_i
  ,output sbox_pkg::perm_t      fwd_perm_o
  ,output sbox_pkg::lane_mask_t fwd_valid_o
  ,output sbox_pkg::perm_t      bkwd_perm_o
  );

   import sbox_pkg::*;

   // sort key wide enough for two lane indices
   typedef logic [2*LG_LANES-1:0] key_t;
   typedef key_t [NUM_LANES-1:0] key_vec_t;

   key_vec_t fwd_key_in;
   key_vec_t fwd_key_out;
   key_vec_t bkwd_key_in;
   key_vec_t bkwd_key_out;

   // compare and exchange, smaller key ends up at position a
   function automatic key_vec_t cmp_xchg(key_vec_t v, int a, int b);
      key_vec_t r;
      r = v;
      if (v[a] > v[b])
      begin
         r[a] = v[b];
         r[b] = v[a];
      end
      return r;
   endfunction

   // five comparator network for four items
   // keys are unique because the lane index is part of them, so order is stable
   function automatic key_vec_t sort4(key_vec_t v);
      key_vec_t s;
      s = cmp_xchg(v, 0, 1);
      s = cmp_xchg(s, 2, 3);
      s = cmp_xchg(s, 0, 2);
      s = cmp_xchg(s, 1, 3);
      s = cmp_xchg(s, 1, 2);
      return s;
   endfunction

   // ******************************
   // forward indices
   // ******************************

   // key is inverted mask bit above the lane index
   // active lanes sort to the front in ascending lane order
   always_comb
   begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
         fwd_key_in[i] = key_t'({~vec_i[i], lane_idx_t'(i)});
      end
      fwd_key_out = sort4(fwd_key_in);
      for (int j = 0; j < NUM_LANES; j++)
      begin
         fwd_perm_o[j]  = fwd_key_out[j][LG_LANES-1:0];
         // output slot j is filled when its source lane was active
         fwd_valid_o[j] = ~fwd_key_out[j][LG_LANES];
      end
   end

   // ******************************
   // backward indices
   // ******************************

   // sorting the pairs by forward index inverts the permutation
   always_comb
   begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
         bkwd_key_in[i] = {fwd_perm_o[i], lane_idx_t'(i)};
      end
      bkwd_key_out = sort4(bkwd_key_in);
      for (int j = 0; j < NUM_LANES; j++)
      begin
         bkwd_perm_o[j] = bkwd_key_out[j][LG_LANES-1:0];
      end
   end

endmodule

/* verilog/sbox_permute.sv */
// lane crossbar selecting one source lane per output lane, over a payload type parameter
`timescale 1ns/1ps

module sbox_permute
  #(parameter type payload_t = logic [7:0]
  )
  (input  sbox_pkg::perm_t      sel_i
  ,input  sbox_pkg::lane_mask_t en_i
  ,input  payload_t             data_i  [sbox_pkg::NUM_LANES]
  ,input  sbox_pkg::lane_mask_t valid_i
  ,output payload_t             data_o  [sbox_pkg::NUM_LANES]
  ,output sbox_pkg::lane_mask_t valid_o
  );

   import sbox_pkg::*;

   // ******************************
   // per output lane mux
   // ******************************

   // data follows the selected source whether enabled or not
   // valid needs both the output enable and the source lane valid
   always_comb
   begin
      for (int j = 0; j < NUM_LANES; j++)
      begin
         data_o[j]  = data_i[sel_i[j]];
         valid_o[j] = en_i[j] & valid_i[sel_i[j]];
      end
   end

endmodule

/* verilog/sbox_drain_timer.sv */
// loadable drain down-counter with a one-cycle done pulse
`timescale 1ns/1ps

module sbox_drain_timer
  (input  logic                            clk_i
  ,input  logic                            rst_n_i
  ,input  logic                            load_i
  ,input  logic [sbox_wb_pkg::DRAIN_W-1:0] len_i
  ,output logic                            done_o
  );

   import sbox_wb_pkg::*;

   logic [DRAIN_W-1:0] cnt_q;
   // set by a load, cleared once done has fired
   logic               armed_q;

   // zero length gives done right in the cycle after the load
   assign done_o = armed_q & (cnt_q == '0);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         cnt_q   <= '0;
         armed_q <= 1'b0;
      end
      else if (load_i)
      begin
         // a reload restarts the count
         cnt_q   <= len_i;
         armed_q <= 1'b1;
      end
      else if (armed_q)
      begin
         if (cnt_q == '0)
         begin
            armed_q <= 1'b0;
         end
         else
         begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

endmodule

/* verilog/sbox_reconfig_fsm.sv */
// reconfiguration FSM sequencing a mask change through drain then apply
`timescale 1ns/1ps

module sbox_reconfig_fsm
  (input  logic                            clk_i
  ,input  logic                            rst_n_i
  ,sbox_cfg_if.fsm_mp                      cfg
  ,output logic                            tmr_load_o
  ,output logic [sbox_wb_pkg::DRAIN_W-1:0] tmr_len_o
  ,input  logic                            tmr_done_i
  );

   import sbox_wb_pkg::*;

   typedef enum logic [1:0]
   {
      IDLE,
      DRAIN,
      APPLY
   } state_t;

   state_t state_q;
   state_t state_d;

   // ******************************
   // next state
   // ******************************

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (cfg.start)
            begin
               state_d = DRAIN;
            end
         end
         // in-flight lane traffic settles while the timer runs
         DRAIN:
         begin
            if (tmr_done_i)
            begin
               state_d = APPLY;
            end
         end
         APPLY:
         begin
            state_d = IDLE;
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   // timer is loaded on the same edge that enters DRAIN
   assign tmr_load_o = (state_q == IDLE) & cfg.start;
   assign tmr_len_o  = cfg.drain_len;

   // busy spans DRAIN and APPLY
   assign cfg.busy = (state_q != IDLE);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_q         <= IDLE;
         cfg.active_mask <= MASK_RESET;
      end
      else
      begin
         state_q <= state_d;
         // takes whatever mask is pending at this point
         if (state_q == APPLY)
         begin
            cfg.active_mask <= cfg.pending_mask;
         end
      end
   end

endmodule

/* verilog/sbox_wb_regs.sv */
// Wishbone classic slave with mask, drain length and status registers
`timescale 1ns/1ps

module sbox_wb_regs
  (input  logic                              clk_i
  ,input  logic                              rst_n_i
  ,input  logic                              cyc_i
  ,input  logic                              stb_i
  ,input  logic                              we_i
  ,input  logic [sbox_wb_pkg::WB_ADDR_W-1:0] adr_i
  ,input  logic [sbox_wb_pkg::WB_DATA_W-1:0] dat_i
  ,output logic [sbox_wb_pkg::WB_DATA_W-1:0] dat_o
  ,output logic                              ack_o
  ,sbox_cfg_if.regs_mp                       cfg
  );

   import sbox_pkg::*;
   import sbox_wb_pkg::*;

   logic                 req;
   logic                 wr_mask;
   logic                 wr_drain;
   logic [WB_DATA_W-1:0] rd_data;

   // ******************************
   // access decode
   // ******************************

   // new request only when no ack is out, so a held strobe is served once
   assign req      = cyc_i & stb_i & ~ack_o;
   assign wr_mask  = req & we_i & (adr_i == ADDR_MASK);
   assign wr_drain = req & we_i & (adr_i == ADDR_DRAIN);

   // read mux, unused bits read as zero
   always_comb
   begin
      rd_data = '0;
      case (adr_i)
         ADDR_MASK:
         begin
            rd_data[NUM_LANES-1:0] = cfg.pending_mask;
         end
         ADDR_DRAIN:
         begin
            rd_data[DRAIN_W-1:0] = cfg.drain_len;
         end
         ADDR_STATUS:
         begin
            rd_data[NUM_LANES-1:0]  = cfg.active_mask;
            rd_data[STATUS_BUSY_BIT] = cfg.busy;
         end
         default:
         begin
            rd_data = '0;
         end
      endcase
   end

   // ******************************
   // registers and handshake
   // ******************************

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ack_o            <= 1'b0;
         cfg.start        <= 1'b0;
         cfg.pending_mask <= MASK_RESET;
         cfg.drain_len    <= DRAIN_RESET;
      end
      else
      begin
         // ack one cycle after the request
         ack_o <= req;
         // a mask write during busy only updates the pending value
         cfg.start <= wr_mask & ~cfg.busy;
         if (wr_mask)
         begin
            cfg.pending_mask <= dat_i[NUM_LANES-1:0];
         end
         if (wr_drain)
         begin
            cfg.drain_len <= dat_i[DRAIN_W-1:0];
         end
      end
   end

   // read data captured with the request, presented in the ack cycle
   always_ff @(posedge clk_i)
   begin
      if (req & ~we_i)
      begin
         dat_o <= rd_data;
      end
   end

endmodule

/* verilog/sbox_top.sv */
// switch box top level with register block, reconfiguration FSM, timer, control and two crossbars
`timescale 1ns/1ps

module sbox_top
  (input  logic                              clk_i
  ,input  logic                              rst_n_i
  // Wishbone classic slave
  ,input  logic                              cyc_i
  ,input  logic                              stb_i
  ,input  logic                              we_i
  ,input  logic [sbox_wb_pkg::WB_ADDR_W-1:0] adr_i
  ,input  logic [sbox_wb_pkg::WB_DATA_W-1:0] dat_i
  ,output logic [sbox_wb_pkg::WB_DATA_W-1:0] dat_o
  ,output logic                              ack_o
  // forward lanes, sparse in and packed out
  ,input  sbox_pkg::fwd_data_t               fwd_data_i  [sbox_pkg::NUM_LANES]
  ,input  sbox_pkg::lane_mask_t              fwd_valid_i
  ,output sbox_pkg::fwd_data_t               fwd_data_o  [sbox_pkg::NUM_LANES]
  ,output sbox_pkg::lane_mask_t              fwd_valid_o
  // return lanes, packed in and sparse out
  ,input  sbox_pkg::ret_data_t               ret_data_i  [sbox_pkg::NUM_LANES]
  ,input  sbox_pkg::lane_mask_t              ret_valid_i
  ,output sbox_pkg::ret_data_t               ret_data_o  [sbox_pkg::NUM_LANES]
  ,output sbox_pkg::lane_mask_t              ret_valid_o
  );

   import sbox_pkg::*;
   import sbox_wb_pkg::*;

   logic               tmr_load;
   logic [DRAIN_W-1:0] tmr_len;
   logic               tmr_done;
   perm_t              fwd_perm;
   lane_mask_t         fwd_en;
   perm_t              bkwd_perm;

   sbox_cfg_if cfg ();

   // ******************************
   // configuration path
   // ******************************

   sbox_wb_regs u_regs
     (.clk_i   (clk_i)
     ,.rst_n_i (rst_n_i)
     ,.cyc_i   (cyc_i)
     ,.stb_i   (stb_i)
     ,.we_i    (we_i)
     ,.adr_i   (adr_i)
     ,.dat_i   (dat_i)
     ,.dat_o   (dat_o)
     ,.ack_o   (ack_o)
     ,.cfg     (cfg.regs_mp)
     );

   sbox_reconfig_fsm u_fsm
     (.clk_i      (clk_i)
     ,.rst_n_i    (rst_n_i)
     ,.cfg        (cfg.fsm_mp)
     ,.tmr_load_o (tmr_load)
     ,.tmr_len_o  (tmr_len)
     ,.tmr_done_i (tmr_done)
     );

   sbox_drain_timer u_timer
     (.clk_i   (clk_i)
     ,.rst_n_i (rst_n_i)
     ,.load_i  (tmr_load)
     ,.len_i   (tmr_len)
     ,.done_o  (tmr_done)
     );

   // ******************************
   // data path
   // ******************************

   // permutations follow the active mask combinationally
   sbox_ctrl_concentrate u_ctrl
     (.vec_i       (cfg.active_mask)
     ,.fwd_perm_o  (fwd_perm)
     ,.fwd_valid_o (fwd_en)
     ,.bkwd_perm_o (bkwd_perm)
     );

   // packs active lanes into the lowest outputs
   sbox_permute #(.payload_t(fwd_data_t)) u_fwd_xbar
     (.sel_i   (fwd_perm)
     ,.en_i    (fwd_en)
     ,.data_i  (fwd_data_i)
     ,.valid_i (fwd_valid_i)
     ,.data_o  (fwd_data_o)
     ,.valid_o (fwd_valid_o)
     );

   // spreads packed return data back to the active lane slots
   sbox_permute #(.payload_t(ret_data_t)) u_ret_xbar
     (.sel_i   (bkwd_perm)
     ,.en_i    (cfg.active_mask)
     ,.data_i  (ret_data_i)
     ,.valid_i (ret_valid_i)
     ,.data_o  (ret_data_o)
     ,.valid_o (ret_valid_o)
     );

endmodule

/* bench/sbox_top_sva.sv */
// assertions on the Wishbone handshake and the reconfiguration sequence, bound to the top level
`timescale 1ns/1ps

module sbox_top_sva
  (input logic                 clk_i
  ,input logic                 rst_n_i
  ,input logic                 cyc_i
  ,input logic                 stb_i
  ,input logic                 ack_i
  ,input logic                 start_i
  ,input logic                 busy_i
  ,input sbox_pkg::lane_mask_t active_mask_i
  );

   // ******************************
   // Wishbone handshake
   // ******************************

   // ack is a single cycle pulse
   a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_i |=> !ack_i)
      else $error("ack held high for more than one cycle");

   // no ack without a request one clock earlier
   a_ack_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(ack_i) |-> $past(cyc_i && stb_i))
      else $error("ack raised without a preceding request");

   // ******************************
   // reconfiguration
   // ******************************

   a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      start_i |-> !busy_i)
      else $error("start raised while a reconfiguration is running");

   // the mask loads on the edge that leaves APPLY
   a_mask_change: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !$stable(active_mask_i) |-> $fell(busy_i))
      else $error("active mask changed outside the end of a reconfiguration");

endmodule

bind sbox_top sbox_top_sva u_sva
  (.clk_i         (clk_i)
  ,.rst_n_i       (rst_n_i)
  ,.cyc_i         (cyc_i)
  ,.stb_i         (stb_i)
  ,.ack_i         (ack_o)
  ,.start_i       (cfg.start)
  ,.busy_i        (cfg.busy)
  ,.active_mask_i (cfg.active_mask)
  );

/* bench/sbox_tb.sv */
// directed testbench for the switch box with clock, reset, Wishbone tasks, reference model and checks
`timescale 1ns/1ps

module sbox_tb;

   import sbox_pkg::*;
   import sbox_wb_pkg::*;

   typedef logic [WB_DATA_W-1:0] word_t;

   // about 16 mask changes of some 20 cycles each, two long drains and status polling
   // stay well below 1000 cycles so the limit leaves a wide margin
   localparam int TIMEOUT_CYCLES = 4000;
   localparam logic [31:0] LFSR_SEED = 32'hac738c87;
   // taps of x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;

   logic                 clk_i = 1'b0;
   logic                 rst_n_i;
   logic                 cyc_i;
   logic                 stb_i;
   logic                 we_i;
   logic [WB_ADDR_W-1:0] adr_i;
   word_t                dat_i;
   word_t                dat_o;
   logic                 ack_o;
   fwd_data_t            fwd_data_i [NUM_LANES];
   lane_mask_t           fwd_valid_i;
   fwd_data_t            fwd_data_o [NUM_LANES];
   lane_mask_t           fwd_valid_o;
   ret_data_t            ret_data_i [NUM_LANES];
   lane_mask_t           ret_valid_i;
   ret_data_t            ret_data_o [NUM_LANES];
   lane_mask_t           ret_valid_o;

   logic [31:0] lfsr_q = LFSR_SEED;
   int          cycle_cnt = 0;
   int          check_cnt = 0;
   int          fwd_errs = 0;
   int          ret_errs = 0;
   int          mask_errs = 0;
   int          word_errs = 0;

   sbox_top u_dut (.*);

   // ******************************
   // clock and watchdog
   // ******************************

   always #2 clk_i = ~clk_i;

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // ******************************
   // random bits and reference model
   // ******************************

   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      if (s[0])
      begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   // one LFSR step per bit taken
   function automatic logic [31:0] next_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < n; b++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // active lanes in ascending order, then the inactive ones
   function automatic perm_t partition(lane_mask_t m);
      perm_t order;
      int    k;
      k = 0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         if (m[i])
         begin
            order[k] = lane_idx_t'(i);
            k++;
         end
      end
      for (int i = 0; i < NUM_LANES; i++)
      begin
         if (!m[i])
         begin
            order[k] = lane_idx_t'(i);
            k++;
         end
      end
      return order;
   endfunction

   function automatic int count_active(lane_mask_t m);
      int n;
      n = 0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         n += int'(m[i]);
      end
      return n;
   endfunction

   // ******************************
   // compare tasks
   // ******************************

   task automatic check_fwd(fwd_data_t got, fwd_data_t exp, string what);
      check_cnt++;
      if (got !== exp)
      begin
         fwd_errs++;
         $display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_ret(ret_data_t got, ret_data_t exp, string what);
      check_cnt++;
      if (got !== exp)
      begin
         ret_errs++;
         $display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_mask(lane_mask_t got, lane_mask_t exp, string what);
      check_cnt++;
      if (got !== exp)
      begin
         mask_errs++;
         $display("CHECK FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_word(word_t got, word_t exp, string what);
      check_cnt++;
      if (got !== exp)
      begin
         word_errs++;
         $display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // ******************************
   // Wishbone master
   // ******************************

   // request driven on a falling edge and ack sampled on the falling edges after it
   task automatic wb_write(logic [WB_ADDR_W-1:0] addr, word_t data);
      @(negedge clk_i);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = 1'b1;
      adr_i = addr;
      dat_i = data;
      @(negedge clk_i);
      while (!ack_o)
      begin
         @(negedge clk_i);
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic wb_read(logic [WB_ADDR_W-1:0] addr, output word_t data);
      @(negedge clk_i);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = 1'b0;
      adr_i = addr;
      @(negedge clk_i);
      while (!ack_o)
      begin
         @(negedge clk_i);
      end
      // read data is valid in the ack cycle
      data  = dat_o;
      cyc_i = 1'b0;
      stb_i = 1'b0;
   endtask

   // poll status until the reconfiguration is over
   task automatic wait_idle(output word_t status);
      word_t st;
      wb_read(ADDR_STATUS, st);
      while (st[8])
      begin
         wb_read(ADDR_STATUS, st);
      end
      status = st;
   endtask

   task automatic set_mask(lane_mask_t m);
      word_t st;
      wb_write(ADDR_MASK, word_t'(m));
      wait_idle(st);
      check_mask(st[NUM_LANES-1:0], m, "active mask after apply");
   endtask

   // ******************************
   // lane stimulus and checks
   // ******************************

   task automatic drive_lanes(lane_mask_t fv, lane_mask_t rv);
      @(negedge clk_i);
      for (int i = 0; i < NUM_LANES; i++)
      begin
         fwd_data_i[i] = fwd_data_t'(next_bits(16));
         ret_data_i[i] = ret_data_t'(next_bits(8));
      end
      fwd_valid_i = fv;
      ret_valid_i = rv;
      // the combinational data path settles well before the next rising edge
      #1;
   endtask

   // all inputs valid, so exactly popcount low outputs are valid
   task automatic check_fwd_lanes(lane_mask_t m);
      perm_t order;
      int    n;
      order = partition(m);
      n = count_active(m);
      drive_lanes('1, '0);
      for (int k = 0; k < NUM_LANES; k++)
      begin
         check_fwd(fwd_data_o[k], fwd_data_i[order[k]],
                   $sformatf("mask %b fwd out %0d", m, k));
      end
      check_mask(fwd_valid_o, lane_mask_t'((1 << n) - 1), $sformatf("mask %b fwd valid", m));
   endtask

   // packed lane k returns to lane order[k] and is valid only where that lane is active
   // packed forward slot k carries the valid of its source lane when k is a filled slot
   task automatic check_ret_lanes(lane_mask_t m);
      perm_t      order;
      int         n;
      lane_mask_t fv;
      lane_mask_t rv;
      lane_mask_t exp_valid;
      lane_mask_t exp_fwd_valid;
      order = partition(m);
      n = count_active(m);
      fv = lane_mask_t'(next_bits(NUM_LANES));
      rv = lane_mask_t'(next_bits(NUM_LANES));
      drive_lanes(fv, rv);
      exp_valid = '0;
      exp_fwd_valid = '0;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         check_ret(ret_data_o[order[k]], ret_data_i[k],
                   $sformatf("mask %b ret from packed %0d", m, k));
         exp_valid[order[k]] = m[order[k]] & rv[k];
         exp_fwd_valid[k] = (k < n) & fv[order[k]];
      end
      check_mask(ret_valid_o, exp_valid, $sformatf("mask %b ret valid", m));
      check_mask(fwd_valid_o, exp_fwd_valid, $sformatf("mask %b fwd valid per source", m));
   endtask

   // ******************************
   // directed tests
   // ******************************

   task automatic test_reset_state();
      word_t rd;
      wb_read(ADDR_STATUS, rd);
      check_word(rd, 32'h0000_000f, "status after reset");
      wb_read(ADDR_DRAIN, rd);
      check_word(rd, 32'd4, "drain length after reset");
      // identity permutation passes the lanes straight through
      drive_lanes('1, '1);
      for (int i = 0; i < NUM_LANES; i++)
      begin
         check_fwd(fwd_data_o[i], fwd_data_i[i], $sformatf("reset fwd lane %0d", i));
         check_ret(ret_data_o[i], ret_data_i[i], $sformatf("reset ret lane %0d", i));
      end
      check_mask(fwd_valid_o, 4'hf, "reset fwd valid");
      check_mask(ret_valid_o, 4'hf, "reset ret valid");
   endtask

   task automatic test_all_masks();
      for (int m = 0; m < 16; m++)
      begin
         set_mask(lane_mask_t'(m));
         check_fwd_lanes(lane_mask_t'(m));
      end
   endtask

   task automatic test_return_path();
      lane_mask_t masks [6];
      masks = '{4'b0101, 4'b1010, 4'b1001, 4'b0110, 4'b0001, 4'b1110};
      foreach (masks[i])
      begin
         set_mask(masks[i]);
         check_ret_lanes(masks[i]);
         check_ret_lanes(masks[i]);
      end
   endtask

   task automatic test_drain_busy();
      word_t rd;
      word_t st;
      wb_write(ADDR_DRAIN, 32'd24);
      wb_read(ADDR_DRAIN, rd);
      check_word(rd, 32'd24, "drain length readback");
      set_mask(4'b0011);
      wb_write(ADDR_MASK, 32'h0000_000c);
      // busy set and the old mask still steering the lanes
      wb_read(ADDR_STATUS, st);
      check_word(st, 32'h0000_0103, "status during drain");
      check_fwd_lanes(4'b0011);
      wait_idle(st);
      check_word(st, 32'h0000_000c, "status after drain");
   endtask

   task automatic test_write_while_busy();
      word_t rd;
      word_t st;
      wb_write(ADDR_MASK, 32'h0000_0009);
      // second write lands inside the drain window
      wb_write(ADDR_MASK, 32'h0000_0006);
      wb_read(ADDR_MASK, rd);
      check_word(rd, 32'h0000_0006, "pending mask after late write");
      wait_idle(st);
      check_word(st, 32'h0000_0006, "late mask applied");
      // another reconfiguration would show busy again here
      repeat (3)
      begin
         wb_read(ADDR_STATUS, st);
         check_word(st, 32'h0000_0006, "status stays idle");
      end
      check_fwd_lanes(4'b0110);
   endtask

   initial
   begin
      rst_n_i     = 1'b0;
      cyc_i       = 1'b0;
      stb_i       = 1'b0;
      we_i        = 1'b0;
      adr_i       = '0;
      dat_i       = '0;
      fwd_valid_i = '0;
      ret_valid_i = '0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         fwd_data_i[i] = '0;
         ret_data_i[i] = '0;
      end
      repeat (8) @(negedge clk_i);
      rst_n_i = 1'b1;

      test_reset_state();
      test_all_masks();
      test_return_path();
      test_drain_busy();
      test_write_while_busy();

      $display("checks %0d, errors: fwd %0d ret %0d mask %0d word %0d",
               check_cnt, fwd_errs, ret_errs, mask_errs, word_errs);
      if (fwd_errs + ret_errs + mask_errs + word_errs == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* build.f */
verilog/sbox_pkg.sv
verilog/sbox_wb_pkg.sv
verilog/sbox_cfg_if.sv
verilog/sbox_ctrl_concentrate.sv
verilog/sbox_permute.sv
verilog/sbox_drain_timer.sv
verilog/sbox_reconfig_fsm.sv
verilog/sbox_wb_regs.sv
verilog/sbox_top.sv
bench/sbox_top_sva.sv
bench/sbox_tb.sv

/* run.sh */
#!/bin/sh
# build the switch box testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module sbox_tb -o sbox_sim

# a failing simulation is judged by the log search below
./obj_dir/sbox_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
